/* hdl/exu_pkg.sv */
// execution stage shared definitions
// data and register index types, opcode and op class enums
// request, writeback and redirect structs
package exu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int LOG2_XLEN = $clog2(XLEN);

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // decoded operation, already resolved upstream
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND, OP_LUI,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } exu_op_e;

    // which unit executes the op
    typedef enum logic [1:0] {
        CLS_ALU,
        CLS_BRU,
        CLS_DIV
    } exu_class_e;

    typedef struct packed {
        exu_op_e   op;
        xlen_t     rs1;
        xlen_t     rs2;
        xlen_t     imm;
        logic      use_imm;
        xlen_t     pc;
        reg_addr_t rd;
    } exu_req_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
    } exu_wb_t;

    // fetch redirect target
    typedef struct packed {
        xlen_t target;
    } exu_redirect_t;

endpackage

/* hdl/exu_dispatch.sv */
// request dispatcher
// op classification, second operand select, issue and divide start
// holds the input while the divider runs
`timescale 1ns/1ns

module exu_dispatch
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      req_valid_i,
    input  exu_req_t  req_i,
    input  logic      div_busy_i,
    input  logic      div_done_i,
    output logic      req_ready_o,
    output exu_op_e   alu_op_o,
    output xlen_t     op_a_o,
    output xlen_t     op_b_o,
    output xlen_t     pc_o,
    output xlen_t     imm_o,
    output logic      issue_o,
    output reg_addr_t rd_o,
    output logic      div_start_o
);

    exu_class_e cls;
    logic       fire;
    reg_addr_t  div_rd_q;

    always_comb begin
        case (req_i.op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
            OP_BLTU, OP_BGEU, OP_JAL, OP_JALR: cls = CLS_BRU;
            OP_DIV, OP_DIVU, OP_REM, OP_REMU:  cls = CLS_DIV;
            default:                           cls = CLS_ALU;
        endcase
    end

    // also low in the done cycle so the divide result goes first
    assign req_ready_o = !div_busy_i && !div_done_i;
    assign fire        = req_valid_i && req_ready_o;
    assign issue_o     = fire && (cls != CLS_DIV);
    assign div_start_o = fire && (cls == CLS_DIV);

    assign alu_op_o = req_i.op;
    assign op_a_o   = req_i.rs1;
    assign pc_o     = req_i.pc;
    assign imm_o    = req_i.imm;
    // branches and divides always compare or divide rs2
    assign op_b_o   = (cls == CLS_ALU && (req_i.use_imm || req_i.op == OP_LUI)) ?
                      req_i.imm : req_i.rs2;

    always_ff @(posedge clk) begin
        if (div_start_o) begin
            div_rd_q <= req_i.rd;
        end
    end

    assign rd_o = div_done_i ? div_rd_q : req_i.rd;

    // source must hold a stalled request
    a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
        req_valid_i && !req_ready_o |=> $stable(req_i));

endmodule

/* hdl/exu_alu.sv */
// integer ALU
// register and immediate arithmetic, logic, shifts, compares and LUI
`timescale 1ns/1ns

module exu_alu
    import exu_pkg::*;
(
    input  exu_op_e alu_op_i,
    input  xlen_t   op_a_i,
    input  xlen_t   op_b_i,
    output xlen_t   result_o,
    output logic    is_alu_o
);

    logic [LOG2_XLEN-1:0] shamt;

    // only the low bits count for shifts
    assign shamt = op_b_i[LOG2_XLEN-1:0];

    always_comb begin
        result_o = '0;
        is_alu_o = 1'b1;
        case (alu_op_i)
            OP_ADD:  result_o = op_a_i + op_b_i;
            OP_SUB:  result_o = op_a_i - op_b_i;
            OP_SLL:  result_o = op_a_i << shamt;
            OP_SLT:  result_o = xlen_t'($signed(op_a_i) < $signed(op_b_i));
            OP_SLTU: result_o = xlen_t'(op_a_i < op_b_i);
            OP_XOR:  result_o = op_a_i ^ op_b_i;
            OP_SRL:  result_o = op_a_i >> shamt;
            OP_SRA:  result_o = xlen_t'($signed(op_a_i) >>> shamt);
            OP_OR:   result_o = op_a_i | op_b_i;
            OP_AND:  result_o = op_a_i & op_b_i;
            // upper immediate arrives already shifted
            OP_LUI:  result_o = op_b_i;
            default: begin
                is_alu_o = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/exu_bru.sv */
// branch unit
// conditional compares, JAL/JALR target and link value
`timescale 1ns/1ns

module exu_bru
    import exu_pkg::*;
(
    input  exu_op_e       bru_op_i,
    input  xlen_t         op_a_i,
    input  xlen_t         op_b_i,
    input  xlen_t         pc_i,
    input  xlen_t         imm_i,
    output logic          taken_o,
    output exu_redirect_t target_o,
    output xlen_t         link_o,
    output logic          writes_link_o
);

    xlen_t jalr_sum;

    always_comb begin
        taken_o       = 1'b0;
        writes_link_o = 1'b0;
        case (bru_op_i)
            OP_BEQ:  taken_o = (op_a_i == op_b_i);
            OP_BNE:  taken_o = (op_a_i != op_b_i);
            OP_BLT:  taken_o = ($signed(op_a_i) < $signed(op_b_i));
            OP_BGE:  taken_o = ($signed(op_a_i) >= $signed(op_b_i));
            OP_BLTU: taken_o = (op_a_i < op_b_i);
            OP_BGEU: taken_o = (op_a_i >= op_b_i);
            OP_JAL, OP_JALR: begin
                taken_o       = 1'b1;
                writes_link_o = 1'b1;
            end
            default: taken_o = 1'b0;
        endcase
    end

    // jalr target has bit 0 forced low
    assign jalr_sum        = op_a_i + imm_i;
    assign target_o.target = (bru_op_i == OP_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign link_o          = pc_i + xlen_t'(4);

endmodule

/* hdl/exu_div.sv */
// iterative divider for DIV, DIVU, REM and REMU
// restoring algorithm, one quotient bit per cycle
// sign fix plus divide by zero and overflow results
`timescale 1ns/1ns

module exu_div
    import exu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    start_i,
    input  exu_op_e op_i,
    input  xlen_t   dividend_i,
    input  xlen_t   divisor_i,
    output logic    busy_o,
    output logic    done_o,
    output xlen_t   result_o
);

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FIX} div_state_e;

    div_state_e           state_q;
    logic [LOG2_XLEN-1:0] cnt_q;
    exu_op_e              op_q;
    xlen_t                dividend_q;
    xlen_t                divisor_q;
    xlen_t                quo_q;
    xlen_t                rem_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 ovf_q;
    logic                 is_signed;
    logic [XLEN:0]        rem_shift;
    logic                 sub_ok;
    xlen_t                rem_step;
    xlen_t                quo_fix;
    xlen_t                rem_fix;

    assign is_signed = (op_i == OP_DIV) || (op_i == OP_REM);
    assign busy_o    = (state_q != DIV_IDLE);

    // shift next dividend bit into partial remainder and try subtracting
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign sub_ok    = (rem_shift >= {1'b0, divisor_q});
    assign rem_step  = sub_ok ? xlen_t'(rem_shift - {1'b0, divisor_q}) : rem_shift[XLEN-1:0];

    always_comb begin
        quo_fix = neg_quo_q ? -quo_q : quo_q;
        rem_fix = neg_rem_q ? -rem_q : rem_q;
        if (divisor_q == '0) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end else if (ovf_q) begin
            quo_fix = dividend_q;
            rem_fix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                DIV_IDLE: if (start_i) begin
                    state_q <= DIV_RUN;
                    cnt_q   <= '0;
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LOG2_XLEN'(XLEN - 1)) begin
                        state_q <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state_q <= DIV_IDLE;
                    done_o  <= 1'b1;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && start_i) begin
            op_q       <= op_i;
            dividend_q <= dividend_i;
            divisor_q  <= (is_signed && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;
            quo_q      <= (is_signed && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
            rem_q      <= '0;
            neg_quo_q  <= is_signed && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_rem_q  <= is_signed && dividend_i[XLEN-1];
            ovf_q      <= is_signed && (dividend_i == {1'b1, {(XLEN-1){1'b0}}})
                          && (divisor_i == '1);
        end else if (state_q == DIV_RUN) begin
            quo_q <= {quo_q[XLEN-2:0], sub_ok};
            rem_q <= rem_step;
        end else if (state_q == DIV_FIX) begin
            result_o <= (op_q == OP_REM || op_q == OP_REMU) ? rem_fix : quo_fix;
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst_i)
        !(start_i && busy_o));

endmodule

/* hdl/exu_wb.sv */
// writeback and redirect register stage
// merges ALU, link and divider results, drops x0 writes
`timescale 1ns/1ns

module exu_wb
    import exu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  logic          issue_i,
    input  reg_addr_t     rd_i,
    input  xlen_t         alu_result_i,
    input  logic          is_alu_i,
    input  logic          taken_i,
    input  exu_redirect_t target_i,
    input  xlen_t         link_i,
    input  logic          writes_link_i,
    input  logic          div_done_i,
    input  xlen_t         div_result_i,
    output logic          wb_valid_o,
    output exu_wb_t       wb_o,
    output logic          redirect_valid_o,
    output exu_redirect_t redirect_o
);

    xlen_t wb_data;
    logic  wb_write;
    logic  redirect;

    always_comb begin
        if (div_done_i) begin
            wb_data = div_result_i;
        end else if (is_alu_i) begin
            wb_data = alu_result_i;
        end else begin
            wb_data = link_i;
        end
    end

    // branches without link write nothing
    assign wb_write = (div_done_i || (issue_i && (is_alu_i || writes_link_i))) && (rd_i != '0);
    assign redirect = issue_i && taken_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o       <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            wb_valid_o       <= wb_write;
            redirect_valid_o <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_write) begin
            wb_o <= '{rd: rd_i, data: wb_data};
        end
        if (redirect) begin
            redirect_o <= target_i;
        end
    end

    // dispatcher holds new requests off during the done cycle
    a_one_source: assert property (@(posedge clk) disable iff (rst_i)
        !(issue_i && div_done_i));

endmodule

/* hdl/exu.sv */
// execution stage top level
// dispatcher, ALU, branch unit, divider and writeback stage
`timescale 1ns/1ns

module exu
    import exu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  logic          req_valid_i,
    output logic          req_ready_o,
    input  exu_req_t      req_i,
    output logic          wb_valid_o,
    output exu_wb_t       wb_o,
    output logic          redirect_valid_o,
    output exu_redirect_t redirect_o
);

    // dispatcher to units
    exu_op_e       alu_op;
    xlen_t         op_a;
    xlen_t         op_b;
    xlen_t         pc;
    xlen_t         imm;
    logic          issue;
    reg_addr_t     rd;
    logic          div_start;
    // unit results
    logic          div_busy;
    logic          div_done;
    xlen_t         div_result;
    xlen_t         alu_result;
    logic          is_alu;
    logic          taken;
    exu_redirect_t target;
    xlen_t         link;
    logic          writes_link;

    exu_dispatch u_exu_dispatch (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .div_busy_i  (div_busy),
        .div_done_i  (div_done),
        .req_ready_o (req_ready_o),
        .alu_op_o    (alu_op),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .pc_o        (pc),
        .imm_o       (imm),
        .issue_o     (issue),
        .rd_o        (rd),
        .div_start_o (div_start)
    );

    exu_alu u_exu_alu (
        .alu_op_i (alu_op),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .result_o (alu_result),
        .is_alu_o (is_alu)
    );

    exu_bru u_exu_bru (
        .bru_op_i      (alu_op),
        .op_a_i        (op_a),
        .op_b_i        (op_b),
        .pc_i          (pc),
        .imm_i         (imm),
        .taken_o       (taken),
        .target_o      (target),
        .link_o        (link),
        .writes_link_o (writes_link)
    );

    exu_div u_exu_div (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (alu_op),
        .dividend_i (op_a),
        .divisor_i  (op_b),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    exu_wb u_exu_wb (
        .clk              (clk),
        .rst_i            (rst_i),
        .issue_i          (issue),
        .rd_i             (rd),
        .alu_result_i     (alu_result),
        .is_alu_i         (is_alu),
        .taken_i          (taken),
        .target_i         (target),
        .link_i           (link),
        .writes_link_i    (writes_link),
        .div_done_i       (div_done),
        .div_result_i     (div_result),
        .wb_valid_o       (wb_valid_o),
        .wb_o             (wb_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_o       (redirect_o)
    );

endmodule

/* test/tb_exu.sv */
// execution stage testbench
// reads requests and expected results from the vector file
// drives the request handshake, checks writeback and redirect in order
`timescale 1ns/1ns

module tb_exu
    import exu_pkg::*;
();

    localparam int COLS     = 12;
    localparam int MAX_VECS = 64;
    localparam int IN_DELAY = 1;

    logic          clk;
    logic          rst_i;
    logic          req_valid_i;
    logic          req_ready_o;
    exu_req_t      req_i;
    logic          wb_valid_o;
    exu_wb_t       wb_o;
    logic          redirect_valid_o;
    exu_redirect_t redirect_o;

    logic [31:0]   stim_mem [0:COLS*MAX_VECS-1];
    int            num_vecs    = 0;
    int            cycle_limit = 0;
    int            cycles      = 0;
    int            errors      = 0;
    int            tests_ok    = 0;
    int            tests_bad   = 0;
    int            checked     = 0;
    int            pending[$];
    int unsigned   lcg_state;

    exu u_exu (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_i            (req_i),
        .wb_valid_o       (wb_valid_o),
        .wb_o             (wb_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_o       (redirect_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic is_div(input exu_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
    endfunction

    // one vector line unpacked into a request
    function automatic exu_req_t vec_req(input int v);
        exu_req_t r;
        int       b;
        b         = v * COLS;
        r.op      = exu_op_e'(stim_mem[b+1][4:0]);
        r.rs1     = stim_mem[b+2];
        r.rs2     = stim_mem[b+3];
        r.imm     = stim_mem[b+4];
        r.use_imm = stim_mem[b+5][0];
        r.pc      = stim_mem[b+6];
        r.rd      = stim_mem[b+7][4:0];
        return r;
    endfunction

    task automatic check_wb(input int num, input exu_wb_t got, input exu_wb_t exp);
        if (got !== exp) begin
            $display("ERROR test %0d wb_o rd %h data %h, expected rd %h data %h",
                     num, got.rd, got.data, exp.rd, exp.data);
            errors++;
        end
    endtask

    task automatic check_redirect(input int num, input exu_redirect_t got,
                                  input exu_redirect_t exp);
        if (got !== exp) begin
            $display("ERROR test %0d redirect_o target %h, expected %h",
                     num, got.target, exp.target);
            errors++;
        end
    endtask

    task automatic check_pulse(input int num, input string name, input logic got,
                               input logic exp);
        if (got !== exp) begin
            if (exp) begin
                $display("test %0d: %s stayed low although a result was due", num, name);
            end else begin
                $display("test %0d: %s pulsed although no result was due", num, name);
            end
            errors++;
        end
    endtask

    // compare this cycle's outputs with the oldest accepted request
    task automatic check_head();
        int            v;
        int            b;
        int            num;
        int            errs_before;
        exu_req_t      req;
        exu_wb_t       exp_wb;
        exu_redirect_t exp_redir;
        v   = pending[0];
        b   = v * COLS;
        num = int'(stim_mem[b]);
        req = vec_req(v);
        // a divide is done once its writeback shows up
        if (is_div(req.op) && !wb_valid_o) begin
            if (redirect_valid_o) begin
                $display("test %0d: redirect_valid_o pulsed during a divide", num);
                errors++;
            end
            return;
        end
        errs_before      = errors;
        exp_wb.rd        = stim_mem[b+7][4:0];
        exp_wb.data      = stim_mem[b+9];
        exp_redir.target = stim_mem[b+11];
        check_pulse(num, "wb_valid_o", wb_valid_o, stim_mem[b+8][0]);
        if (wb_valid_o && stim_mem[b+8][0]) begin
            check_wb(num, wb_o, exp_wb);
        end
        check_pulse(num, "redirect_valid_o", redirect_valid_o, stim_mem[b+10][0]);
        if (redirect_valid_o && stim_mem[b+10][0]) begin
            check_redirect(num, redirect_o, exp_redir);
        end
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %0d: ok", num);
        end else begin
            tests_bad++;
            $display("test %0d: mismatch", num);
        end
        void'(pending.pop_front());
        checked++;
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        if (!rst_i) begin
            if (pending.size() != 0) begin
                check_head();
            end else if (wb_valid_o || redirect_valid_o) begin
                $display("output pulse with no request outstanding at cycle %0d", cycles);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int   idle;
        int   waited;
        logic after_div;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        lcg_state   = 61;
        after_div   = 1'b0;
        $readmemh("test/exu_stim.txt", stim_mem);
        while (num_vecs < MAX_VECS && !$isunknown(stim_mem[num_vecs*COLS])) begin
            num_vecs++;
        end
        cycle_limit = num_vecs * 40 + 100;
        repeat (5) @(posedge clk);
        #IN_DELAY;
        rst_i = 1'b0;
        for (int v = 0; v < num_vecs; v++) begin
            lcg_state = lcg_next(lcg_state);
            idle      = (lcg_state >> 16) & 3;
            repeat (idle) begin
                @(posedge clk);
                #IN_DELAY;
            end
            req_valid_i = 1'b1;
            req_i       = vec_req(v);
            waited      = 0;
            @(negedge clk);
            while (!req_ready_o) begin
                waited++;
                @(negedge clk);
            end
            // a request behind a divide must wait for its result
            if (after_div && waited == 0) begin
                $display("test %0d: request accepted while the divider was busy",
                         int'(stim_mem[v*COLS]));
                errors++;
            end else if (after_div && !wb_valid_o) begin
                $display("test %0d: request accepted before the divide result appeared",
                         int'(stim_mem[v*COLS]));
                errors++;
            end
            @(posedge clk);
            pending.push_back(v);
            #IN_DELAY;
            after_div   = is_div(req_i.op);
            req_valid_i = 1'b0;
            req_i       = '0;
        end
        wait (checked == num_vecs);
        // room for a stray late pulse
        repeat (3) @(posedge clk);
        $display("%0d tests, %0d ok, %0d with mismatches, %0d errors in total",
                 num_vecs, tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0 && num_vecs > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/exu_stim.txt */
// num op rs1 rs2 imm use_imm pc rd wb_valid wb_data redirect_valid target, all hex
// op is the opcode enum position, 00 add to 0a lui, 0b beq to 12 jalr, 13 div to 16 remu
01 00 00000005 00000007 00000000 0 00001000 01 1 0000000c 0 00000000
02 00 00000010 deadbeef fffffffc 1 00001004 02 1 0000000c 0 00000000
03 01 00000003 00000005 00000000 0 00001008 03 1 fffffffe 0 00000000
04 02 00000001 00000024 00000000 0 0000100c 04 1 00000010 0 00000000
05 03 fffffff0 00000001 00000000 0 00001010 05 1 00000001 0 00000000
06 04 fffffff0 00000001 00000000 0 00001014 06 1 00000000 0 00000000
07 05 0f0f0f0f 00000000 ffffffff 1 00001018 07 1 f0f0f0f0 0 00000000
08 06 80000000 0000001f 00000000 0 0000101c 08 1 00000001 0 00000000
09 07 80000010 00000000 00000004 1 00001020 09 1 f8000001 0 00000000
0a 08 12340000 00005678 00000000 0 00001024 0a 1 12345678 0 00000000
0b 09 ffff00ff 00000000 00000ff0 1 00001028 0b 1 000000f0 0 00000000
0c 0a 00000000 00000000 abcde000 0 0000102c 0c 1 abcde000 0 00000000
0d 00 00000001 00000001 00000000 0 00001030 00 0 00000000 0 00000000
0e 0b 00000042 00000042 00000010 0 00002000 0d 0 00000000 1 00002010
0f 0c 00000005 00000005 00000020 0 00002004 0d 0 00000000 0 00000000
10 0d ffffffff 00000001 fffffff8 0 00002008 0d 0 00000000 1 00002000
11 0e ffffffff 00000001 00000010 0 0000200c 0d 0 00000000 0 00000000
12 0f ffffffff 00000001 00000008 0 00002010 0d 0 00000000 0 00000000
13 10 ffffffff 00000001 00000100 0 00002014 0d 0 00000000 1 00002114
14 11 00000000 00000000 00000400 0 00003000 01 1 00003004 1 00003400
15 12 00004001 00000000 00000006 1 00003010 05 1 00003014 1 00004006
16 11 00000000 00000000 fffffff0 0 00003020 00 0 00000000 1 00003010
17 13 ffffffec 00000003 00000000 0 00004000 10 1 fffffffa 0 00000000
18 15 ffffffec 00000003 00000000 0 00004004 11 1 fffffffe 0 00000000
19 14 ffffffec 00000003 00000000 0 00004008 12 1 5555554e 0 00000000
1a 16 ffffffec 00000003 00000000 0 0000400c 13 1 00000002 0 00000000
1b 13 00000007 00000000 00000000 0 00004010 14 1 ffffffff 0 00000000
1c 16 00001234 00000000 00000000 0 00004014 15 1 00001234 0 00000000
1d 13 80000000 ffffffff 00000000 0 00004018 16 1 80000000 0 00000000
1e 15 80000000 ffffffff 00000000 0 0000401c 17 1 00000000 0 00000000
1f 00 00000100 00000023 00000000 0 00004020 18 1 00000123 0 00000000
20 13 00000007 fffffffe 00000000 0 00004024 19 1 fffffffd 0 00000000

/* sim.f */
hdl/exu_pkg.sv
hdl/exu_dispatch.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_div.sv
hdl/exu_wb.sv
hdl/exu.sv
test/tb_exu.sv
